/* Bender.yml */
package:
  name: clint

export_include_dirs:
  - .

sources:
  - files:
      - apb_pkg.sv
      - clint_pkg.sv
      - clint_prescaler.sv
      - mtimer.sv
      - msip_reg.sv
      - clint_apb_router.sv
      - clint_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - clint_props.sv
      - tb_clint.sv

/* apb_pkg.sv */
package apb_pkg;

    // Completion status of one APB transfer
    typedef enum logic {
        resp_okay   = 1'b0,
        resp_slverr = 1'b1
    } apb_resp_e;

    // Number of byte lanes on the 32-bit data bus
    localparam int unsigned APB_STRB_W = 4;

    // All byte lanes enabled
    localparam logic [APB_STRB_W-1:0] APB_STRB_FULL = '1;

endpackage

/* clint_apb_router.sv */
`include "clint_macros.svh"

module clint_apb_router (
    input  logic                     psel,
    input  logic [`CLINT_ADDR_W-1:0] paddr,
    output logic                     pready,
    output logic                     psel_timer,
    output logic                     psel_msip,
    input  logic [`CLINT_DATA_W-1:0] prdata_timer,
    input  logic                     pslverr_timer,
    input  logic [`CLINT_DATA_W-1:0] prdata_msip,
    input  logic                     pslverr_msip,
    output logic [`CLINT_DATA_W-1:0] prdata,
    output logic                     pslverr
);

    localparam logic [`CLINT_ADDR_W-1:0] MSIP_BASE = `CLINT_MSIP_OFF;

    clint_pkg::region_e region;

    // Top two address bits pick the region
    assign region = (paddr[15:14] == MSIP_BASE[15:14]) ? clint_pkg::region_msip
                                                       : clint_pkg::region_timer;

    assign psel_timer = psel && (region == clint_pkg::region_timer);
    assign psel_msip  = psel && (region == clint_pkg::region_msip);

    always_comb begin
        if (region == clint_pkg::region_msip) begin
            prdata  = prdata_msip;
            pslverr = pslverr_msip;
        end else begin
            prdata  = prdata_timer;
            pslverr = pslverr_timer;
        end
    end

    // No wait states in either slave
    assign pready = 1'b1;

endmodule

/* clint_macros.svh */
`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// Bus widths
`define CLINT_ADDR_W        16
`define CLINT_DATA_W        32

// Register offsets
`define CLINT_MTIME_OFF     16'h0000
`define CLINT_MTIMEH_OFF    16'h0004
`define CLINT_MSIP_OFF      16'h4000
`define CLINT_MTIMECMP_OFF  16'h8000
`define CLINT_MTIMECMPH_OFF 16'h8004

// Compare value after reset, so no timer interrupt until written
`define CLINT_MTIMECMP_RST  64'hffff_ffff_ffff_ffff

// Default clocks per mtime increment
`define CLINT_TICK_DIV      4

`endif

/* clint_pkg.sv */
package clint_pkg;

    // Register addressed by the exact offset inside a region
    typedef enum logic [2:0] {
        sel_mtime_lo    = 3'd0,
        sel_mtime_hi    = 3'd1,
        sel_mtimecmp_lo = 3'd2,
        sel_mtimecmp_hi = 3'd3,
        sel_msip        = 3'd4,
        sel_none        = 3'd7
    } reg_sel_e;

    // Coarse region from paddr[15:14]
    typedef enum logic {
        region_timer = 1'b0,
        region_msip  = 1'b1
    } region_e;

endpackage

/* clint_prescaler.sv */
`include "clint_macros.svh"

module clint_prescaler #(
    parameter int unsigned DIV = `CLINT_TICK_DIV
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    // One bit minimum so DIV of 1 still elaborates
    localparam int unsigned CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count == LAST) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // High on the final count of each period
    assign tick = (count == LAST);

endmodule

/* clint_props.sv */
`include "clint_macros.svh"

module clint_props (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       psel,
    input logic                       penable,
    input logic                       pready,
    input logic [`CLINT_ADDR_W-1:0]   paddr,
    input logic                       pwrite,
    input logic [`CLINT_DATA_W-1:0]   pwdata,
    input logic [`CLINT_DATA_W/8-1:0] pwstrb,
    input logic [63:0]                mtime,
    input logic [63:0]                mtimecmp,
    input logic                       mtimer_int,
    input logic                       msip_int
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;
    logic        full_wr;
    logic        msip_written;

    assign full_wr = psel && penable && pwrite && (&pwstrb);

    // Goes high at the first committed msip write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_written <= 1'b0;
        end else if (full_wr && (paddr == `CLINT_MSIP_OFF)) begin
            msip_written <= 1'b1;
        end
    end

    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready) else begin
        $error("pready went low");
        fail_cnt++;
    end

    a_int_match: assert property (@(posedge clk) disable iff (!rst_n)
        mtimer_int == (mtime >= mtimecmp)) else begin
        $error("mtimer_int disagrees with mtime >= mtimecmp");
        fail_cnt++;
    end

    a_cmp_lo_write: assert property (@(posedge clk) disable iff (!rst_n)
        full_wr && (paddr == `CLINT_MTIMECMP_OFF) |=> mtimecmp[31:0] == $past(pwdata)) else begin
        $error("mtimecmp low half did not take the written data");
        fail_cnt++;
    end

    a_cmp_hi_write: assert property (@(posedge clk) disable iff (!rst_n)
        full_wr && (paddr == `CLINT_MTIMECMPH_OFF) |=> mtimecmp[63:32] == $past(pwdata)) else begin
        $error("mtimecmp high half did not take the written data");
        fail_cnt++;
    end

    a_msip_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !msip_written |-> !msip_int) else begin
        $error("msip_int rose without an msip write");
        fail_cnt++;
    end

endmodule

bind clint_top clint_props u_props (
    .mtimecmp (u_mtimer.mtimecmp),
    .*
);

/* clint_top.sv */
`include "clint_macros.svh"

module clint_top #(
    parameter int unsigned DIV = `CLINT_TICK_DIV
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    output logic                       pready,
    input  logic [`CLINT_ADDR_W-1:0]   paddr,
    input  logic                       pwrite,
    input  logic [`CLINT_DATA_W-1:0]   pwdata,
    input  logic [`CLINT_DATA_W/8-1:0] pwstrb,
    output logic [`CLINT_DATA_W-1:0]   prdata,
    output logic                       pslverr,
    output logic [63:0]                mtime,
    output logic                       mtimer_int,
    output logic                       msip_int
);

    logic                     tick;
    logic                     psel_timer;
    logic                     psel_msip;
    logic [`CLINT_DATA_W-1:0] prdata_timer;
    logic                     pslverr_timer;
    logic [`CLINT_DATA_W-1:0] prdata_msip;
    logic                     pslverr_msip;

    clint_prescaler #(
        .DIV (DIV)
    ) u_prescaler (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    clint_apb_router u_router (
        .psel          (psel),
        .paddr         (paddr),
        .pready        (pready),
        .psel_timer    (psel_timer),
        .psel_msip     (psel_msip),
        .prdata_timer  (prdata_timer),
        .pslverr_timer (pslverr_timer),
        .prdata_msip   (prdata_msip),
        .pslverr_msip  (pslverr_msip),
        .prdata        (prdata),
        .pslverr       (pslverr)
    );

    mtimer u_mtimer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .psel       (psel_timer),
        .penable    (penable),
        .paddr      (paddr),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pwstrb     (pwstrb),
        .prdata     (prdata_timer),
        .pslverr    (pslverr_timer),
        .mtime      (mtime),
        .mtimer_int (mtimer_int)
    );

    msip_reg u_msip (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel_msip),
        .penable  (penable),
        .paddr    (paddr),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pwstrb   (pwstrb),
        .prdata   (prdata_msip),
        .pslverr  (pslverr_msip),
        .msip_int (msip_int)
    );

endmodule

/* filelist.f */
+incdir+.
apb_pkg.sv
clint_pkg.sv
clint_prescaler.sv
mtimer.sv
msip_reg.sv
clint_apb_router.sv
clint_top.sv
tb_clk_gen.sv
clint_props.sv
tb_clint.sv

/* msip_reg.sv */
`include "clint_macros.svh"

module msip_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic [`CLINT_ADDR_W-1:0]   paddr,
    input  logic                       pwrite,
    input  logic [`CLINT_DATA_W-1:0]   pwdata,
    input  logic [`CLINT_DATA_W/8-1:0] pwstrb,
    output logic [`CLINT_DATA_W-1:0]   prdata,
    output logic                       pslverr,
    output logic                       msip_int
);

    clint_pkg::reg_sel_e sel;
    apb_pkg::apb_resp_e  resp;
    logic                wr_en;
    logic                msip;

    assign sel = (paddr == `CLINT_MSIP_OFF) ? clint_pkg::sel_msip : clint_pkg::sel_none;

    // Same full-strobe rule as the timer
    assign resp    = (pwrite && (pwstrb != apb_pkg::APB_STRB_FULL)) ? apb_pkg::resp_slverr
                                                                    : apb_pkg::resp_okay;
    assign pslverr = (resp == apb_pkg::resp_slverr);
    assign wr_en   = psel && penable && pwrite && (resp == apb_pkg::resp_okay)
                     && (sel == clint_pkg::sel_msip);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip <= 1'b0;
        end else if (wr_en) begin
            msip <= pwdata[0];
        end
    end

    // Only bit 0 is implemented
    assign prdata   = (sel == clint_pkg::sel_msip) ? `CLINT_DATA_W'(msip) : '0;
    assign msip_int = msip;

endmodule

/* mtimer.sv */
`include "clint_macros.svh"

module mtimer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       tick,
    input  logic                       psel,
    input  logic                       penable,
    input  logic [`CLINT_ADDR_W-1:0]   paddr,
    input  logic                       pwrite,
    input  logic [`CLINT_DATA_W-1:0]   pwdata,
    input  logic [`CLINT_DATA_W/8-1:0] pwstrb,
    output logic [`CLINT_DATA_W-1:0]   prdata,
    output logic                       pslverr,
    output logic [63:0]                mtime,
    output logic                       mtimer_int
);

    localparam logic [63:0] CMP_RST = `CLINT_MTIMECMP_RST;

    clint_pkg::reg_sel_e  sel;
    apb_pkg::apb_resp_e   resp;
    logic                 wr_en;
    logic [63:0]          next_mtime;
    logic [31:0]          mtimecmp_lo;
    logic [31:0]          mtimecmp_hi;
    logic [63:0]          mtimecmp;

    always_comb begin
        case (paddr)
            `CLINT_MTIME_OFF:     sel = clint_pkg::sel_mtime_lo;
            `CLINT_MTIMEH_OFF:    sel = clint_pkg::sel_mtime_hi;
            `CLINT_MTIMECMP_OFF:  sel = clint_pkg::sel_mtimecmp_lo;
            `CLINT_MTIMECMPH_OFF: sel = clint_pkg::sel_mtimecmp_hi;
            default:              sel = clint_pkg::sel_none;
        endcase
    end

    // Partial writes are refused
    assign resp    = (pwrite && (pwstrb != apb_pkg::APB_STRB_FULL)) ? apb_pkg::resp_slverr
                                                                    : apb_pkg::resp_okay;
    assign pslverr = (resp == apb_pkg::resp_slverr);
    assign wr_en   = psel && penable && pwrite && (resp == apb_pkg::resp_okay);

    // Increment only on prescaler ticks
    assign next_mtime = mtime + 64'(tick);

    // Half writes keep this edge's increment in the other half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_en && (sel == clint_pkg::sel_mtime_lo)) begin
            mtime <= {next_mtime[63:32], pwdata};
        end else if (wr_en && (sel == clint_pkg::sel_mtime_hi)) begin
            mtime <= {pwdata, next_mtime[31:0]};
        end else begin
            mtime <= next_mtime;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_lo <= CMP_RST[31:0];
        end else if (wr_en && (sel == clint_pkg::sel_mtimecmp_lo)) begin
            mtimecmp_lo <= pwdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_hi <= CMP_RST[63:32];
        end else if (wr_en && (sel == clint_pkg::sel_mtimecmp_hi)) begin
            mtimecmp_hi <= pwdata;
        end
    end

    assign mtimecmp = {mtimecmp_hi, mtimecmp_lo};

    always_comb begin
        case (sel)
            clint_pkg::sel_mtime_lo:    prdata = mtime[31:0];
            clint_pkg::sel_mtime_hi:    prdata = mtime[63:32];
            clint_pkg::sel_mtimecmp_lo: prdata = mtimecmp_lo;
            clint_pkg::sel_mtimecmp_hi: prdata = mtimecmp_hi;
            default:                    prdata = '0;
        endcase
    end

    // Level interrupt, held until compare is moved past time
    assign mtimer_int = (mtime >= mtimecmp);

endmodule

/* tb_clint.sv */
`include "clint_macros.svh"

module tb_clint;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIV = `CLINT_TICK_DIV;

    logic                       clk;
    logic                       rst_n;
    logic                       psel;
    logic                       penable;
    logic                       pready;
    logic [`CLINT_ADDR_W-1:0]   paddr;
    logic                       pwrite;
    logic [`CLINT_DATA_W-1:0]   pwdata;
    logic [`CLINT_DATA_W/8-1:0] pwstrb;
    logic [`CLINT_DATA_W-1:0]   prdata;
    logic                       pslverr;
    logic [63:0]                mtime;
    logic                       mtimer_int;
    logic                       msip_int;

    // Reference model state, valid for the current cycle
    int                         m_cnt;
    logic [63:0]                m_time;
    logic [63:0]                m_cmp;
    logic                       m_msip;
    logic [31:0]                lfsr_q;

    tb_clk_gen u_clk_gen (.*);

    clint_top UUT (.*);

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic timeout_fail(input string why);
        $display("Timeout: %s", why);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_time(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input apb_pkg::apb_resp_e exp,
                              input apb_pkg::apb_resp_e act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
            abort_run();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] model_rdata(input logic [15:0] a);
        case (a)
            `CLINT_MTIME_OFF:     return m_time[31:0];
            `CLINT_MTIMEH_OFF:    return m_time[63:32];
            `CLINT_MTIMECMP_OFF:  return m_cmp[31:0];
            `CLINT_MTIMECMPH_OFF: return m_cmp[63:32];
            `CLINT_MSIP_OFF:      return {31'b0, m_msip};
            default:              return '0;
        endcase
    endfunction

    // One rising edge of the CLINT
    function automatic void model_step();
        logic [63:0] nt;
        nt = m_time + ((m_cnt == DIV - 1) ? 64'd1 : 64'd0);
        if (psel && penable && pwrite && (pwstrb == 4'hf)) begin
            case (paddr)
                `CLINT_MTIME_OFF:     nt[31:0] = pwdata;
                `CLINT_MTIMEH_OFF:    nt[63:32] = pwdata;
                `CLINT_MTIMECMP_OFF:  m_cmp[31:0] = pwdata;
                `CLINT_MTIMECMPH_OFF: m_cmp[63:32] = pwdata;
                `CLINT_MSIP_OFF:      m_msip = pwdata[0];
                default: ;
            endcase
        end
        m_time = nt;
        m_cnt  = (m_cnt == DIV - 1) ? 0 : m_cnt + 1;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            m_cnt  = 0;
            m_time = '0;
            m_cmp  = `CLINT_MTIMECMP_RST;
            m_msip = 1'b0;
        end else begin
            // Stop as soon as a bound assertion has fired
            if (UUT.u_props.fail_cnt != 0) begin
                abort_run();
            end
            check_time("mtime", m_time, mtime);
            check_flag("mtimer_int", m_time >= m_cmp, mtimer_int);
            check_flag("msip_int", m_msip, msip_int);
            if (psel && penable) begin
                check_resp("pslverr", (pwrite && pwstrb != 4'hf) ? apb_pkg::resp_slverr
                                                                 : apb_pkg::resp_okay,
                           apb_pkg::apb_resp_e'(pslverr));
                if (!pwrite) begin
                    check_word("prdata", model_rdata(paddr), prdata);
                end
            end
            model_step();
        end
    end

    // Setup and access cycle, called and returning on a falling edge
    task automatic apb_xfer(input logic wr, input logic [15:0] a, input logic [31:0] d,
                            input logic [3:0] s);
        int n;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        pwstrb  = s;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        @(posedge clk);
        while (!pready) begin
            n++;
            if (n > 8) timeout_fail("APB access never saw pready");
            @(posedge clk);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin
        int          n;
        logic [31:0] d;
        logic [15:0] a;
        logic [3:0]  s;
        psel    = 1'b0;
        penable = 1'b0;
        paddr   = '0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pwstrb  = '0;
        lfsr_q  = 32'hce7c;
        n = 0;
        while (rst_n !== 1'b1) begin
            n++;
            if (n > 10) timeout_fail("reset was never released");
            @(posedge clk);
        end
        @(negedge clk);

        // Reset values
        apb_xfer(1'b0, `CLINT_MTIME_OFF, '0, '0);
        apb_xfer(1'b0, `CLINT_MTIMEH_OFF, '0, '0);
        apb_xfer(1'b0, `CLINT_MTIMECMP_OFF, '0, '0);
        apb_xfer(1'b0, `CLINT_MTIMECMPH_OFF, '0, '0);
        apb_xfer(1'b0, `CLINT_MSIP_OFF, '0, '0);
        repeat (3 * DIV) @(negedge clk);

        // Random half writes with read back
        for (int i = 0; i < 8; i++) begin
            d = lfsr_bits(2);
            a = {d[1], 12'h000, d[0], 2'b00};
            apb_xfer(1'b1, a, lfsr_bits(32), 4'hf);
            apb_xfer(1'b0, a, '0, '0);
        end

        // Second low write lands on a tick while the low half is all ones
        n = 0;
        while (m_cnt != 0) begin
            n++;
            if (n > 2 * DIV) timeout_fail("prescaler count never wrapped");
            @(negedge clk);
        end
        apb_xfer(1'b1, `CLINT_MTIME_OFF, 32'hffff_ffff, 4'hf);
        apb_xfer(1'b1, `CLINT_MTIME_OFF, lfsr_bits(32), 4'hf);
        apb_xfer(1'b0, `CLINT_MTIMEH_OFF, '0, '0);

        // Compare a few ticks ahead of time
        apb_xfer(1'b1, `CLINT_MTIMEH_OFF, '0, 4'hf);
        apb_xfer(1'b1, `CLINT_MTIME_OFF, '0, 4'hf);
        apb_xfer(1'b1, `CLINT_MTIMECMP_OFF, 32'hffff_ffff, 4'hf);
        apb_xfer(1'b1, `CLINT_MTIMECMPH_OFF, '0, 4'hf);
        apb_xfer(1'b1, `CLINT_MTIMECMP_OFF, m_time[31:0] + 32'd4, 4'hf);
        n = 0;
        while (!mtimer_int) begin
            n++;
            if (n > 8 * DIV) timeout_fail("mtimer_int never rose");
            @(negedge clk);
        end
        repeat (2 * DIV) @(negedge clk);
        apb_xfer(1'b1, `CLINT_MTIMECMP_OFF, m_time[31:0] + 32'd100, 4'hf);
        repeat (DIV) @(negedge clk);

        // Software interrupt set then cleared
        d = lfsr_bits(32);
        apb_xfer(1'b1, `CLINT_MSIP_OFF, d | 32'd1, 4'hf);
        apb_xfer(1'b0, `CLINT_MSIP_OFF, '0, '0);
        apb_xfer(1'b1, `CLINT_MSIP_OFF, d & ~32'd1, 4'hf);
        apb_xfer(1'b0, `CLINT_MSIP_OFF, '0, '0);

        // Partial strobes are refused
        for (int i = 0; i < 6; i++) begin
            d = lfsr_bits(7);
            s = (d[3:0] == 4'hf) ? 4'h7 : d[3:0];
            a = d[6] ? `CLINT_MSIP_OFF : {d[5], 12'h000, d[4], 2'b00};
            apb_xfer(1'b1, a, lfsr_bits(32), s);
            apb_xfer(1'b0, a, '0, '0);
        end

        // Bit 3 set never hits a mapped offset
        for (int i = 0; i < 6; i++) begin
            d = lfsr_bits(16);
            a = d[15:0] | 16'h0008;
            apb_xfer(1'b1, a, lfsr_bits(32), 4'hf);
            apb_xfer(1'b0, a, '0, '0);
        end
        repeat (DIV) @(negedge clk);

        if (UUT.u_props.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Bound assertions reported failures");
        end
    end

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for four cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
